// ==== hdl/fetch_pkg.sv ====
// fetch package: shared widths, sizes, types and enums for the fetch subsystem
package fetch_pkg;

    ////////////////////
    // widths and sizes
    ////////////////////

    // fetch address and instruction word
    localparam int PC_W   = 32;
    localparam int INST_W = 32;

    // one instruction per fetch, no compressed forms
    localparam int INST_BYTES = 4;

    // direct-mapped btb geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    // index sits above the two byte-offset bits
    localparam int BTB_TAG_W   = PC_W - BTB_IDX_W - 2;

    // decode buffer depth = credits after reset
    localparam int DECODE_CREDITS = 4;
    localparam int CREDIT_W       = $clog2(DECODE_CREDITS + 1);

    ////////////////////
    // types
    ////////////////////

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [CREDIT_W-1:0]  credit_t;

    // config register map
    typedef enum logic [1:0] {
        CFG_ENABLE     = 2'd0,
        CFG_BTB_ENABLE = 2'd1,
        CFG_RESTART_PC = 2'd2
    } cfg_reg_e;

    // fetch unit fsm
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_RUN  = 1'b1
    } fetch_state_e;

endpackage

// ==== hdl/fetch_ifs.sv ====
// fetch interfaces: config-to-fetch control bus and fetch-to-btb lookup bus
`timescale 1ns/1ns

// config block -> fetch unit
interface fetch_cfg_if;
    logic           enable;
    logic           btb_enable;
    // one-cycle pulse after a restart pc write
    logic           restart_valid;
    fetch_pkg::pc_t restart_pc;

    modport source (output enable, output btb_enable, output restart_valid, output restart_pc);
    modport sink   (input enable, input btb_enable, input restart_valid, input restart_pc);
endinterface

// fetch unit <-> btb, same-cycle lookup
interface btb_if;
    fetch_pkg::pc_t lookup_pc;
    logic           hit;
    fetch_pkg::pc_t target;
    // gates the hit, comes from the config block
    logic           btb_enable;

    // fetch side
    modport lookup (output lookup_pc, input hit, input target);
    // table side
    modport tbl (input lookup_pc, input btb_enable, output hit, output target);
endinterface

// ==== hdl/fetch_cfg.sv ====
// fetch config block: decodes register writes into enable, btb enable and restart control
`timescale 1ns/1ns

module fetch_cfg (
    input  logic                 CLK,
    input  logic                 rst_n,

    // register write port
    input  logic                 cfg_wr_valid,
    input  fetch_pkg::cfg_reg_e  cfg_wr_addr,
    input  fetch_pkg::pc_t       cfg_wr_data,

    // steering out to fetch
    fetch_cfg_if.source          cfg
);

    // register state
    logic           enable_q;
    logic           btb_enable_q;
    fetch_pkg::pc_t restart_pc_q;
    logic           restart_valid_q;

    ////////////////////
    // write decode
    ////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            enable_q        <= 1'b0;
            // predictor on by default
            btb_enable_q    <= 1'b1;
            restart_pc_q    <= '0;
            restart_valid_q <= 1'b0;
        end else begin
            // pulse only for the cycle after the write
            restart_valid_q <= 1'b0;
            if (cfg_wr_valid) begin
                case (cfg_wr_addr)
                    fetch_pkg::CFG_ENABLE:     enable_q     <= cfg_wr_data[0];
                    fetch_pkg::CFG_BTB_ENABLE: btb_enable_q <= cfg_wr_data[0];
                    fetch_pkg::CFG_RESTART_PC: begin
                        restart_pc_q    <= cfg_wr_data;
                        // redirect fetch
                        restart_valid_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // drive the bus
    assign cfg.enable        = enable_q;
    assign cfg.btb_enable    = btb_enable_q;
    assign cfg.restart_valid = restart_valid_q;
    assign cfg.restart_pc    = restart_pc_q;

endmodule

// ==== hdl/fetch_btb.sv ====
// fetch btb: direct-mapped branch target buffer with same-cycle lookup and branch training
`timescale 1ns/1ns

module fetch_btb (
    input  logic            CLK,
    input  logic            rst_n,

    // lookup from fetch
    btb_if.tbl              btb,

    // training from resolved branches
    input  logic            bru_valid,
    input  fetch_pkg::pc_t  bru_src_pc,
    input  fetch_pkg::pc_t  bru_tgt_pc,
    input  logic            bru_taken
);

    // entry arrays
    logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
    fetch_pkg::btb_tag_t               tag_q [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::pc_t                    target_q [fetch_pkg::BTB_ENTRIES];

    // split addresses into index and tag
    fetch_pkg::btb_idx_t lookup_idx;
    fetch_pkg::btb_tag_t lookup_tag;
    fetch_pkg::btb_idx_t train_idx;
    fetch_pkg::btb_tag_t train_tag;
    logic                train_tag_match;

    assign lookup_idx = btb.lookup_pc[fetch_pkg::BTB_IDX_W+1:2];
    assign lookup_tag = btb.lookup_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_IDX_W+2];
    assign train_idx  = bru_src_pc[fetch_pkg::BTB_IDX_W+1:2];
    assign train_tag  = bru_src_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_IDX_W+2];

    ////////////////////
    // lookup
    ////////////////////

    // hit gated by the btb enable bit
    assign btb.hit    = btb.btb_enable && valid_q[lookup_idx] &&
                        (tag_q[lookup_idx] == lookup_tag);
    assign btb.target = target_q[lookup_idx];

    ////////////////////
    // training
    ////////////////////

    assign train_tag_match = valid_q[train_idx] && (tag_q[train_idx] == train_tag);

    // valid bits
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (bru_valid) begin
            if (bru_taken) begin
                valid_q[train_idx] <= 1'b1;
            end else if (train_tag_match) begin
                // not taken, drop the stale entry
                valid_q[train_idx] <= 1'b0;
            end
        end
    end

    // tag and target payload, written on taken only
    always_ff @(posedge CLK) begin
        if (bru_valid && bru_taken) begin
            tag_q[train_idx]    <= train_tag;
            target_q[train_idx] <= bru_tgt_pc;
        end
    end

endmodule

// ==== hdl/fetch_unit.sv ====
// fetch unit: pc generation, REQ/RESP pipeline, restart squash and decode credit counter
`timescale 1ns/1ns

module fetch_unit (
    input  logic              CLK,
    input  logic              rst_n,

    // control from config block
    fetch_cfg_if.sink         cfg,

    // next-pc prediction
    btb_if.lookup             btb,

    // instruction memory, one-cycle response
    output logic              imem_req_valid,
    output fetch_pkg::pc_t    imem_req_addr,
    input  fetch_pkg::inst_t  imem_resp_data,

    // decode, credit flow control
    output logic              fetch_valid,
    output fetch_pkg::pc_t    fetch_pc,
    output fetch_pkg::inst_t  fetch_inst,
    input  logic              decode_credit
);

    // fsm
    fetch_pkg::fetch_state_e state_q;

    // REQ stage
    fetch_pkg::pc_t   req_pc_q;
    fetch_pkg::pc_t   cur_pc;
    fetch_pkg::pc_t   next_pc;
    logic             issue;

    // RESP stage
    logic             resp_valid_q;
    fetch_pkg::pc_t   resp_pc_q;
    logic             squash;

    // credits
    fetch_pkg::credit_t credits_q;
    fetch_pkg::credit_t credits_next;

    ////////////////////
    // REQ stage
    ////////////////////

    // restart overrides the held pc in its own cycle
    assign cur_pc = cfg.restart_valid ? cfg.restart_pc : req_pc_q;

    // btb looks at the pc being requested
    assign btb.lookup_pc = cur_pc;

    // predicted target on hit, else sequential
    assign next_pc = btb.hit ? btb.target : cur_pc + fetch_pkg::pc_t'(fetch_pkg::INST_BYTES);

    // one request per cycle while running with credit
    assign issue = (state_q == fetch_pkg::FETCH_RUN) && (credits_q != '0);

    assign imem_req_valid = issue;
    assign imem_req_addr  = cur_pc;

    // fsm follows the enable bit
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end else if (cfg.enable) begin
            state_q <= fetch_pkg::FETCH_RUN;
        end else begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end
    end

    // pc holds when nothing issues, but still takes a restart
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            req_pc_q <= '0;
        end else if (issue) begin
            req_pc_q <= next_pc;
        end else begin
            req_pc_q <= cur_pc;
        end
    end

    ////////////////////
    // RESP stage
    ////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= issue;
        end
    end

    // pc travels with the request
    always_ff @(posedge CLK) begin
        if (issue) begin
            resp_pc_q <= cur_pc;
        end
    end

    // in-flight response belongs to the old path
    assign squash = resp_valid_q && cfg.restart_valid;

    assign fetch_valid = resp_valid_q && !cfg.restart_valid;
    assign fetch_pc    = resp_pc_q;
    assign fetch_inst  = imem_resp_data;

    ////////////////////
    // credits
    ////////////////////

    // spend on issue, refund on decode return or squash
    assign credits_next = credits_q
                        + fetch_pkg::credit_t'(decode_credit)
                        + fetch_pkg::credit_t'(squash)
                        - fetch_pkg::credit_t'(issue);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= fetch_pkg::credit_t'(fetch_pkg::DECODE_CREDITS);
        end else begin
            credits_q <= credits_next;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
// fetch top: joins config block, fetch unit and btb behind plain outside ports
`timescale 1ns/1ns

module fetch_top (
    input  logic                 CLK,
    input  logic                 rst_n,

    // config writes
    input  logic                 cfg_wr_valid,
    input  fetch_pkg::cfg_reg_e  cfg_wr_addr,
    input  fetch_pkg::pc_t       cfg_wr_data,

    // instruction memory
    output logic                 imem_req_valid,
    output fetch_pkg::pc_t       imem_req_addr,
    input  fetch_pkg::inst_t     imem_resp_data,

    // decode
    output logic                 fetch_valid,
    output fetch_pkg::pc_t       fetch_pc,
    output fetch_pkg::inst_t     fetch_inst,
    input  logic                 decode_credit,

    // branch training
    input  logic                 bru_valid,
    input  fetch_pkg::pc_t       bru_src_pc,
    input  fetch_pkg::pc_t       bru_tgt_pc,
    input  logic                 bru_taken
);

    // internal buses
    fetch_cfg_if cfg_bus ();
    btb_if       btb_bus ();

    // btb enable from config into the btb bus
    assign btb_bus.btb_enable = cfg_bus.btb_enable;

    fetch_cfg u_cfg (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .cfg_wr_valid (cfg_wr_valid),
        .cfg_wr_addr  (cfg_wr_addr),
        .cfg_wr_data  (cfg_wr_data),
        .cfg          (cfg_bus.source)
    );

    fetch_unit u_fetch (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .cfg            (cfg_bus.sink),
        .btb            (btb_bus.lookup),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_resp_data (imem_resp_data),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .decode_credit  (decode_credit)
    );

    fetch_btb u_btb (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .btb        (btb_bus.tbl),
        .bru_valid  (bru_valid),
        .bru_src_pc (bru_src_pc),
        .bru_tgt_pc (bru_tgt_pc),
        .bru_taken  (bru_taken)
    );

endmodule

// ==== sim/fetch_clk_gen.sv ====
// fetch clock and reset generator: 10 ns clock, reset low for the first three cycles
`timescale 1ns/1ns

module fetch_clk_gen (
    output logic CLK,
    output logic rst_n
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // release just after the third edge, aligned with stimulus
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== sim/fetch_sva.sv ====
// fetch assertions: credit bound and fetch_valid only after a request
`timescale 1ns/1ns

module fetch_sva (
    input logic               CLK,
    input logic               rst_n,
    input fetch_pkg::credit_t credits_q,
    input logic               imem_req_valid,
    input logic               fetch_valid
);

    // counter never above the decode buffer depth
    property credit_bound;
        @(posedge CLK) disable iff (!rst_n)
            credits_q <= fetch_pkg::credit_t'(fetch_pkg::DECODE_CREDITS);
    endproperty

    // a response needs a request one cycle earlier
    property valid_after_req;
        @(posedge CLK) disable iff (!rst_n)
            fetch_valid |-> $past(imem_req_valid);
    endproperty

    a_credit_bound: assert property (credit_bound)
        else $error("credit count above the decode buffer depth");

    a_valid_after_req: assert property (valid_after_req)
        else $error("fetch_valid without a request in the previous cycle");

endmodule

// attach to every fetch unit
bind fetch_unit fetch_sva u_sva (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .credits_q      (credits_q),
    .imem_req_valid (imem_req_valid),
    .fetch_valid    (fetch_valid)
);

// ==== sim/fetch_tb.sv ====
// fetch testbench with memory and decode models and directed tests of the fetch subsystem
`timescale 1ns/1ns

module fetch_tb;

    // dut ports
    logic                cfg_wr_valid;
    fetch_pkg::cfg_reg_e cfg_wr_addr;
    fetch_pkg::pc_t      cfg_wr_data;
    logic                imem_req_valid;
    fetch_pkg::pc_t      imem_req_addr;
    fetch_pkg::inst_t    imem_resp_data;
    logic                fetch_valid;
    fetch_pkg::pc_t      fetch_pc;
    fetch_pkg::inst_t    fetch_inst;
    logic                decode_credit;
    logic                bru_valid;
    fetch_pkg::pc_t      bru_src_pc;
    fetch_pkg::pc_t      bru_tgt_pc;
    logic                bru_taken;
    logic                CLK;
    logic                rst_n;

    // memory data key
    integer              seed;
    fetch_pkg::inst_t    key;
    // what reached decode in order
    fetch_pkg::pc_t      got_pc[$];
    fetch_pkg::inst_t    got_inst[$];
    // trained branch targets by source pc
    fetch_pkg::pc_t      pred[fetch_pkg::pc_t];
    logic                model_btb_en;
    // decode holds its credits while set
    logic                hold;
    int                  owed;
    int                  errors;
    int                  tests_run;
    int                  tests_bad;

    fetch_clk_gen u_clk (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    fetch_top uut (.*);

    ////////////////////
    // models
    ////////////////////

    // imem answers one cycle after the request with addr ^ key
    initial begin : mem_model
        fetch_pkg::pc_t addr;
        logic           req;
        imem_resp_data = '0;
        forever begin
            @(negedge CLK);
            req  = imem_req_valid;
            addr = imem_req_addr;
            @(posedge CLK);
            #1;
            if (req) begin
                imem_resp_data = addr ^ key;
            end
        end
    end

    // decode records outputs and pays back one credit per cycle
    initial begin : decode_model
        logic give;
        decode_credit = 1'b0;
        owed          = 0;
        forever begin
            @(negedge CLK);
            if (fetch_valid) begin
                got_pc.push_back(fetch_pc);
                got_inst.push_back(fetch_inst);
                owed = owed + 1;
            end
            give = !hold && (owed > 0);
            if (give) begin
                owed = owed - 1;
            end
            @(posedge CLK);
            #1;
            decode_credit = give;
        end
    end

    ////////////////////
    // compares
    ////////////////////

    task automatic check_pc(string name, fetch_pkg::pc_t got, fetch_pkg::pc_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(string name, fetch_pkg::inst_t got, fetch_pkg::inst_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // helpers
    ////////////////////

    // step to 1 ns after the next edge
    task automatic tick(int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic cfg_write(fetch_pkg::cfg_reg_e addr, fetch_pkg::pc_t data);
        cfg_wr_valid = 1'b1;
        cfg_wr_addr  = addr;
        cfg_wr_data  = data;
        tick(1);
        cfg_wr_valid = 1'b0;
    endtask

    // resolved branch into dut and model
    task automatic train(fetch_pkg::pc_t src, fetch_pkg::pc_t tgt, logic taken);
        bru_valid  = 1'b1;
        bru_src_pc = src;
        bru_tgt_pc = tgt;
        bru_taken  = taken;
        tick(1);
        bru_valid = 1'b0;
        if (taken) begin
            pred[src] = tgt;
        end else begin
            pred.delete(src);
        end
    endtask

    // target on a known taken branch, else next word
    function automatic fetch_pkg::pc_t model_next(fetch_pkg::pc_t pc);
        if (model_btb_en && pred.exists(pc)) begin
            return pred[pc];
        end
        return pc + 32'd4;
    endfunction

    task automatic start_at(fetch_pkg::pc_t pc);
        got_pc.delete();
        got_inst.delete();
        cfg_write(fetch_pkg::CFG_RESTART_PC, pc);
        cfg_write(fetch_pkg::CFG_ENABLE, 32'd1);
    endtask

    // disable and let in-flight work and credits drain
    task automatic stop_fetch();
        cfg_write(fetch_pkg::CFG_ENABLE, 32'd0);
        tick(8);
    endtask

    task automatic wait_fetches(int n, int max_cycles);
        int c;
        c = 0;
        while (got_pc.size() < n && c < max_cycles) begin
            tick(1);
            c++;
        end
        if (got_pc.size() < n) begin
            $display("timeout at %0t: only %0d of %0d instructions reached decode",
                     $time, got_pc.size(), n);
            errors++;
        end
    endtask

    // n recorded outputs from index first follow the next-pc rule
    task automatic verify_stream(fetch_pkg::pc_t start, int first, int n);
        fetch_pkg::pc_t exp;
        exp = start;
        for (int i = first; i < first + n && i < got_pc.size(); i++) begin
            check_pc("fetch_pc", got_pc[i], exp);
            check_inst("fetch_inst", got_inst[i], exp ^ key);
            exp = model_next(exp);
        end
    endtask

    task automatic run_from(fetch_pkg::pc_t pc, int n);
        start_at(pc);
        wait_fetches(n, 4 * n + 20);
        verify_stream(pc, 0, n);
        stop_fetch();
    endtask

    task automatic finish_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_idle();
        int e;
        e = errors;
        repeat (6) begin
            check_flag("imem_req_valid", imem_req_valid, 1'b0);
            check_flag("fetch_valid", fetch_valid, 1'b0);
            tick(1);
        end
        finish_test("reset_idle", e);
    endtask

    task automatic seq_fetch();
        int e;
        e = errors;
        run_from(32'h0000_0100, 8);
        finish_test("seq_fetch", e);
    endtask

    // decode keeps its credits and then lets them go
    task automatic credit_backpressure(string name, fetch_pkg::pc_t pc);
        int e;
        e = errors;
        hold = 1'b1;
        start_at(pc);
        wait_fetches(fetch_pkg::DECODE_CREDITS, 20);
        tick(10);
        if (got_pc.size() != fetch_pkg::DECODE_CREDITS) begin
            $display("%s: %0d instructions reached decode on %0d credits",
                     name, got_pc.size(), fetch_pkg::DECODE_CREDITS);
            errors++;
        end
        check_flag("imem_req_valid", imem_req_valid, 1'b0);
        hold = 1'b0;
        // no gap or repeat across the stall
        wait_fetches(12, 40);
        verify_stream(pc, 0, 12);
        stop_fetch();
        finish_test(name, e);
    endtask

    task automatic branch_predict();
        fetch_pkg::pc_t src;
        fetch_pkg::pc_t tgt;
        int             e;
        e   = errors;
        src = 32'h0000_0240;
        tgt = 32'h0000_0800;
        // src is the fifth fetch from src - 16
        train(src, tgt, 1'b1);
        run_from(src - 32'd16, 10);
        check_pc("fetch_pc after taken branch", got_pc[5], tgt);
        train(src, tgt, 1'b0);
        run_from(src - 32'd16, 10);
        check_pc("fetch_pc after not-taken training", got_pc[5], src + 32'd4);
        // entry present with the predictor off
        train(src, tgt, 1'b1);
        cfg_write(fetch_pkg::CFG_BTB_ENABLE, 32'd0);
        model_btb_en = 1'b0;
        run_from(src - 32'd16, 10);
        check_pc("fetch_pc with btb disabled", got_pc[5], src + 32'd4);
        cfg_write(fetch_pkg::CFG_BTB_ENABLE, 32'd1);
        model_btb_en = 1'b1;
        train(src, tgt, 1'b0);
        finish_test("branch_predict", e);
    endtask

    task automatic restart_midstream();
        int e;
        int n0;
        int k;
        e = errors;
        start_at(32'h0000_0400);
        wait_fetches(6, 40);
        n0 = got_pc.size();
        cfg_write(fetch_pkg::CFG_RESTART_PC, 32'h0000_0c00);
        // restart cycle requests the new pc and drops the in-flight response
        check_pc("imem_req_addr", imem_req_addr, 32'h0000_0c00);
        check_flag("fetch_valid", fetch_valid, 1'b0);
        wait_fetches(n0 + 10, 60);
        // first output on the new path
        k = -1;
        for (int i = 0; i < got_pc.size(); i++) begin
            if (k < 0 && got_pc[i] == 32'h0000_0c00) begin
                k = i;
            end
        end
        if (k < 0) begin
            $display("restart_midstream: the stream never reached the restart PC");
            errors++;
        end else begin
            verify_stream(32'h0000_0400, 0, k);
            verify_stream(32'h0000_0c00, k, got_pc.size() - k);
        end
        stop_fetch();
        finish_test("restart_midstream", e);
    endtask

    ////////////////////
    // main
    ////////////////////

    initial begin
        cfg_wr_valid = 1'b0;
        cfg_wr_addr  = fetch_pkg::CFG_ENABLE;
        cfg_wr_data  = '0;
        bru_valid    = 1'b0;
        bru_src_pc   = '0;
        bru_tgt_pc   = '0;
        bru_taken    = 1'b0;
        hold         = 1'b0;
        model_btb_en = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        seed         = 32'h1495f3d6;
        key          = $random(seed);
        @(posedge rst_n);
        tick(1);
        reset_idle();
        seq_fetch();
        credit_backpressure("credit_backpressure", 32'h0000_0100);
        branch_predict();
        restart_midstream();
        // same pattern again to show the credits are still balanced
        credit_backpressure("credit_rerun", 32'h0000_0600);
        $display("%0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog covers six tests of at most 100 cycles plus 200 cycles margin
    initial begin
        #((6 * 100 + 200) * 10);
        $display("timeout: the tests did not finish in the expected time");
        $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/fetch_pkg.sv
hdl/fetch_ifs.sv
hdl/fetch_cfg.sv
hdl/fetch_btb.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
sim/fetch_clk_gen.sv
sim/fetch_sva.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f src.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
